/* common/periph_params.svh */
// ==============================
// Port bases, EMS windows and reset values for the XT peripheral glue.
// Port bases are full 16-bit I/O addresses; windows are address[19:16].
// ==============================
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// I/O port map
`define PERIPH_IO_EMS_BASE      16'h0260
`define PERIPH_IO_LPT_ADDR      16'h0378
`define PERIPH_IO_NMI_BASE      16'h00A0

// EMS frame window base nibbles
`define PERIPH_EMS_WIN_A        4'hA
`define PERIPH_EMS_WIN_C        4'hC
`define PERIPH_EMS_WIN_D        4'hD

// Four 16 KB slots per 64 KB frame
`define PERIPH_EMS_PAGES        4

// Written to a slot register, this byte unmaps the slot
`define PERIPH_EMS_DISABLE_CODE 8'hFF

// Latch values after reset
`define PERIPH_LPT_RESET        8'hFF
`define PERIPH_NMI_RESET        8'hFF

`endif

/* common/periph_pkg.sv */
// ==============================
// Shared types for the peripheral glue.
// EMS command byte is decoded through a packed union.
// ==============================
package periph_pkg;

    // One byte of the chipset data bus
    typedef logic [7:0] bus_byte_t;

    // Physical EMS page number
    typedef logic [6:0] ems_page_t;

    // Bit 7 set marks a command that does not load a page
    typedef struct packed {
        logic       high;
        ems_page_t  page;
    } ems_cmd_fields_t;

    // Same byte seen raw or split into flag and page
    typedef union packed {
        bus_byte_t          raw;
        ems_cmd_fields_t    fields;
    } ems_cmd_u;

endpackage

/* src/io_decode.sv */
// ==============================
// Combinational I/O decoder, zero cycle latency.
// Selects are active only inside an I/O read or write
// with address_enable_n_i low.
// ==============================
`timescale 1ns/100ps
`include "periph_params.svh"

module io_decode (
    input  logic [19:0] address_i,
    input  logic        address_enable_n_i,
    input  logic        io_read_n_i,
    input  logic        io_write_n_i,
    input  logic        ems_enabled_i,
    input  logic        tandy_mode_i,
    output logic        dma_cs_n_o,
    output logic        pic_cs_n_o,
    output logic        pit_cs_n_o,
    output logic        ppi_cs_n_o,
    output logic        dma_page_cs_n_o,
    output logic        pic_sel_o,
    output logic        pit_sel_o,
    output logic        ppi_sel_o,
    output logic        ems_sel_o,
    output logic        lpt_sel_o,
    output logic        nmi_sel_o
);

    localparam logic [15:0] EMS_BASE = `PERIPH_IO_EMS_BASE;
    localparam logic [15:0] LPT_ADDR = `PERIPH_IO_LPT_ADDR;
    localparam logic [15:0] NMI_BASE = `PERIPH_IO_NMI_BASE;

    logic       io_request;
    logic       low_block;
    logic [4:0] low_sel;

    assign io_request = ~address_enable_n_i & (~io_read_n_i | ~io_write_n_i);

    // Ports 000h-0FFh, one 32-port group per chip
    assign low_block = io_request & (address_i[9:8] == 2'b00);

    always_comb begin
        for (int k = 0; k < 5; k++) begin
            low_sel[k] = low_block & (address_i[7:5] == k[2:0]);
        end
    end

    assign dma_cs_n_o      = ~low_sel[0];
    assign pic_cs_n_o      = ~low_sel[1];
    assign pit_cs_n_o      = ~low_sel[2];
    assign ppi_cs_n_o      = ~low_sel[3];
    assign dma_page_cs_n_o = ~low_sel[4];

    assign pic_sel_o = low_sel[1];
    assign pit_sel_o = low_sel[2];
    assign ppi_sel_o = low_sel[3];

    // 260h-263h
    assign ems_sel_o = io_request & ems_enabled_i & (address_i[15:2] == EMS_BASE[15:2]);

    assign lpt_sel_o = io_request & (address_i[15:0] == LPT_ADDR);

    // A0h-A7h, Tandy only
    assign nmi_sel_o = io_request & tandy_mode_i & (address_i[15:3] == NMI_BASE[15:3]);

endmodule

/* ems/ems_mapper.sv */
// ==============================
// EMS page table for four 16 KB slots.
// A write lands in the table one edge after it is sampled.
// Hits are flagged only outside I/O strobes.
// ==============================
`timescale 1ns/100ps
`include "periph_params.svh"

module ems_mapper (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    ems_sel_i,
    input  logic                    io_read_n_i,
    input  logic                    io_write_n_i,
    input  logic [1:0]              ems_window_i,
    input  logic [19:0]             address_i,
    input  periph_pkg::bus_byte_t   data_i,
    output periph_pkg::bus_byte_t   ems_read_data_o,
    output logic [3:0]              ems_hit_o
);

    import periph_pkg::*;

    ems_cmd_u                       cmd;
    logic                           cmd_disable;
    logic                           cmd_load;
    logic                           wr_enable;
    logic                           wr_load;
    logic [1:0]                     wr_slot;
    ems_page_t                      wr_page;
    ems_page_t                      page_table [`PERIPH_EMS_PAGES];
    logic [`PERIPH_EMS_PAGES-1:0]   page_enable;
    logic [3:0]                     window_base;

    assign cmd.raw     = data_i;
    assign cmd_disable = (cmd.raw == `PERIPH_EMS_DISABLE_CODE);
    assign cmd_load    = ~cmd.fields.high;

    // Bytes 80h-FEh are ignored, so they never raise the write enable
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_enable <= 1'b0;
        end
        else begin
            wr_enable <= ems_sel_i & ~io_write_n_i & (cmd_disable | cmd_load);
        end
    end

    always_ff @(posedge clock) begin
        wr_slot <= address_i[1:0];
        wr_load <= cmd_load;
        wr_page <= cmd.fields.page;
    end

    // FFh clears only the enable, the page is kept
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            page_enable <= '0;
        end
        else if (wr_enable) begin
            page_enable[wr_slot] <= wr_load;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_enable && wr_load) begin
            page_table[wr_slot] <= wr_page;
        end
    end

    assign ems_read_data_o = page_enable[address_i[1:0]]
                           ? {1'b0, page_table[address_i[1:0]]}
                           : `PERIPH_EMS_DISABLE_CODE;

    always_comb begin
        case (ems_window_i)
            2'd0:    window_base = `PERIPH_EMS_WIN_A;
            2'd1:    window_base = `PERIPH_EMS_WIN_C;
            default: window_base = `PERIPH_EMS_WIN_D;
        endcase
    end

    // Slot k covers window + k * 16 KB
    always_comb begin
        for (int k = 0; k < `PERIPH_EMS_PAGES; k++) begin
            ems_hit_o[k] = io_read_n_i & io_write_n_i & page_enable[k]
                         & (address_i[19:16] == window_base)
                         & (address_i[15:14] == k[1:0]);
        end
    end

endmodule

/* src/port_latches.sv */
// ==============================
// LPT data and NMI-mask write latches.
// Both load on the write edge and reset to FFh.
// ==============================
`timescale 1ns/100ps
`include "periph_params.svh"

module port_latches (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    io_write_n_i,
    input  logic                    lpt_sel_i,
    input  logic                    nmi_sel_i,
    input  periph_pkg::bus_byte_t   data_i,
    output periph_pkg::bus_byte_t   lpt_data_o,
    output periph_pkg::bus_byte_t   nmi_mask_o
);

    logic lpt_write;
    logic nmi_write;

    assign lpt_write = lpt_sel_i & ~io_write_n_i;
    assign nmi_write = nmi_sel_i & ~io_write_n_i;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data_o <= `PERIPH_LPT_RESET;
        end
        else if (lpt_write) begin
            lpt_data_o <= data_i;
        end
    end

    // Tandy NMI mask, kept only as a readable register
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            nmi_mask_o <= `PERIPH_NMI_RESET;
        end
        else if (nmi_write) begin
            nmi_mask_o <= data_i;
        end
    end

endmodule

/* src/read_mux.sv */
// ==============================
// Registered read-back onto the chipset data bus.
// One cycle latency, interrupt acknowledge wins over any read.
// ==============================
`timescale 1ns/100ps

module read_mux (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    io_read_n_i,
    input  logic                    interrupt_acknowledge_n_i,
    input  logic                    pic_sel_i,
    input  logic                    pit_sel_i,
    input  logic                    ppi_sel_i,
    input  logic                    ems_sel_i,
    input  logic                    lpt_sel_i,
    input  logic                    nmi_sel_i,
    input  periph_pkg::bus_byte_t   pic_data_i,
    input  periph_pkg::bus_byte_t   pit_data_i,
    input  periph_pkg::bus_byte_t   ppi_data_i,
    input  periph_pkg::bus_byte_t   ems_data_i,
    input  periph_pkg::bus_byte_t   lpt_data_i,
    input  periph_pkg::bus_byte_t   nmi_mask_i,
    output periph_pkg::bus_byte_t   data_bus_out_o,
    output logic                    data_bus_out_from_chipset_o
);

    logic io_read;

    assign io_read = ~io_read_n_i;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_out_from_chipset_o <= 1'b0;
            data_bus_out_o              <= 8'h00;
        end
        else begin
            data_bus_out_from_chipset_o <= 1'b1;
            // PIC supplies the vector during acknowledge
            if (~interrupt_acknowledge_n_i) begin
                data_bus_out_o <= pic_data_i;
            end
            else if (pic_sel_i && io_read) begin
                data_bus_out_o <= pic_data_i;
            end
            else if (pit_sel_i && io_read) begin
                data_bus_out_o <= pit_data_i;
            end
            else if (ppi_sel_i && io_read) begin
                data_bus_out_o <= ppi_data_i;
            end
            else if (ems_sel_i && io_read) begin
                data_bus_out_o <= ems_data_i;
            end
            else if (lpt_sel_i && io_read) begin
                data_bus_out_o <= lpt_data_i;
            end
            else if (nmi_sel_i && io_read) begin
                data_bus_out_o <= nmi_mask_i;
            end
            else begin
                data_bus_out_from_chipset_o <= 1'b0;
                data_bus_out_o              <= 8'h00;
            end
        end
    end

endmodule

/* src/periph_glue_top.sv */
// ==============================
// XT peripheral glue top level.
// PIC, PIT and PPI sit outside; they get chip selects
// here and return their read data.
// ==============================
`timescale 1ns/100ps

module periph_glue_top (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [19:0]             address_i,
    input  periph_pkg::bus_byte_t   data_i,
    input  logic                    address_enable_n_i,
    input  logic                    io_read_n_i,
    input  logic                    io_write_n_i,
    // Memory strobes are part of the bus, no block here needs them
    input  logic                    memory_read_n_i,
    input  logic                    memory_write_n_i,
    input  logic                    interrupt_acknowledge_n_i,
    input  logic                    ems_enabled_i,
    input  logic [1:0]              ems_window_i,
    input  logic                    tandy_mode_i,
    input  periph_pkg::bus_byte_t   pic_data_i,
    input  periph_pkg::bus_byte_t   pit_data_i,
    input  periph_pkg::bus_byte_t   ppi_data_i,
    output logic                    dma_cs_n_o,
    output logic                    pic_cs_n_o,
    output logic                    pit_cs_n_o,
    output logic                    ppi_cs_n_o,
    output logic                    dma_page_cs_n_o,
    output logic [3:0]              ems_hit_o,
    output periph_pkg::bus_byte_t   data_bus_out_o,
    output logic                    data_bus_out_from_chipset_o
);

    import periph_pkg::*;

    logic       pic_sel;
    logic       pit_sel;
    logic       ppi_sel;
    logic       ems_sel;
    logic       lpt_sel;
    logic       nmi_sel;
    bus_byte_t  ems_read_data;
    bus_byte_t  lpt_data;
    bus_byte_t  nmi_mask;

    io_decode u_io_decode (
        .address_i          (address_i),
        .address_enable_n_i (address_enable_n_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .ems_enabled_i      (ems_enabled_i),
        .tandy_mode_i       (tandy_mode_i),
        .dma_cs_n_o         (dma_cs_n_o),
        .pic_cs_n_o         (pic_cs_n_o),
        .pit_cs_n_o         (pit_cs_n_o),
        .ppi_cs_n_o         (ppi_cs_n_o),
        .dma_page_cs_n_o    (dma_page_cs_n_o),
        .pic_sel_o          (pic_sel),
        .pit_sel_o          (pit_sel),
        .ppi_sel_o          (ppi_sel),
        .ems_sel_o          (ems_sel),
        .lpt_sel_o          (lpt_sel),
        .nmi_sel_o          (nmi_sel)
    );

    ems_mapper u_ems_mapper (
        .clock              (clock),
        .reset              (reset),
        .ems_sel_i          (ems_sel),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .ems_window_i       (ems_window_i),
        .address_i          (address_i),
        .data_i             (data_i),
        .ems_read_data_o    (ems_read_data),
        .ems_hit_o          (ems_hit_o)
    );

    port_latches u_port_latches (
        .clock              (clock),
        .reset              (reset),
        .io_write_n_i       (io_write_n_i),
        .lpt_sel_i          (lpt_sel),
        .nmi_sel_i          (nmi_sel),
        .data_i             (data_i),
        .lpt_data_o         (lpt_data),
        .nmi_mask_o         (nmi_mask)
    );

    read_mux u_read_mux (
        .clock                       (clock),
        .reset                       (reset),
        .io_read_n_i                 (io_read_n_i),
        .interrupt_acknowledge_n_i   (interrupt_acknowledge_n_i),
        .pic_sel_i                   (pic_sel),
        .pit_sel_i                   (pit_sel),
        .ppi_sel_i                   (ppi_sel),
        .ems_sel_i                   (ems_sel),
        .lpt_sel_i                   (lpt_sel),
        .nmi_sel_i                   (nmi_sel),
        .pic_data_i                  (pic_data_i),
        .pit_data_i                  (pit_data_i),
        .ppi_data_i                  (ppi_data_i),
        .ems_data_i                  (ems_read_data),
        .lpt_data_i                  (lpt_data),
        .nmi_mask_i                  (nmi_mask),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

/* sim/tb_periph_glue.sv */
// ==============================
// Directed testbench for periph_glue_top.
// Inputs change 1 ns after the rising edge.
// PIC, PIT and PPI read data are random with a fixed seed.
// ==============================
`timescale 1ns/100ps
`include "periph_params.svh"

module tb_periph_glue;

    import periph_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    // Rough cycle budget of each test, doubled for the watchdog
    localparam int RUN_CYCLES   = RESET_CYCLES + 10 + 40 + 20 + 40 + 60 + 20;
    localparam int WATCHDOG_NS  = 2 * RUN_CYCLES * CLK_PERIOD;

    localparam logic [19:0] LPT_PORT = {4'h0, `PERIPH_IO_LPT_ADDR};
    localparam logic [19:0] NMI_PORT = {4'h0, `PERIPH_IO_NMI_BASE};
    localparam logic [19:0] EMS_PORT = {4'h0, `PERIPH_IO_EMS_BASE};

    logic        clock = 1'b0;
    logic        reset;
    logic [19:0] address_i;
    bus_byte_t   data_i;
    logic        address_enable_n_i;
    logic        io_read_n_i;
    logic        io_write_n_i;
    logic        memory_read_n_i;
    logic        memory_write_n_i;
    logic        interrupt_acknowledge_n_i;
    logic        ems_enabled_i;
    logic [1:0]  ems_window_i;
    logic        tandy_mode_i;
    bus_byte_t   pic_data_i;
    bus_byte_t   pit_data_i;
    bus_byte_t   ppi_data_i;
    logic        dma_cs_n_o;
    logic        pic_cs_n_o;
    logic        pit_cs_n_o;
    logic        ppi_cs_n_o;
    logic        dma_page_cs_n_o;
    logic [3:0]  ems_hit_o;
    bus_byte_t   data_bus_out_o;
    logic        data_bus_out_from_chipset_o;

    integer      seed = 32'h32d1_7093;
    integer      errors = 0;
    // Expected EMS table, kept from the write rule
    logic [6:0]  model_page [4];
    logic        model_en [4];

    periph_glue_top dut0 (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not finish in time (%0d errors)", errors);
        $display("TB FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        assert (got === expected)
        else begin
            $display("ERROR %s: got %h, expected %h at %0t", name, got, expected, $time);
            errors++;
        end
    endtask

    task automatic bus_idle();
        address_enable_n_i        = 1'b1;
        io_read_n_i               = 1'b1;
        io_write_n_i              = 1'b1;
        memory_read_n_i           = 1'b1;
        memory_write_n_i          = 1'b1;
        interrupt_acknowledge_n_i = 1'b1;
    endtask

    task automatic io_write(input logic [19:0] addr, input bus_byte_t data);
        address_i          = addr;
        data_i             = data;
        address_enable_n_i = 1'b0;
        io_write_n_i       = 1'b0;
        @(posedge clock);
        #1;
        bus_idle();
    endtask

    // Result is registered on the edge that samples the read
    task automatic read_and_check(input logic [19:0] addr, input bus_byte_t exp_data,
                                  input logic exp_flag);
        address_i          = addr;
        address_enable_n_i = 1'b0;
        io_read_n_i        = 1'b0;
        @(posedge clock);
        #1;
        check_value("data_bus_out_from_chipset_o", data_bus_out_from_chipset_o, exp_flag);
        check_value("data_bus_out_o", data_bus_out_o, exp_data);
        bus_idle();
    endtask

    function automatic bus_byte_t ems_expected(input int slot);
        return model_en[slot] ? {1'b0, model_page[slot]} : 8'hFF;
    endfunction

    function automatic logic [3:0] window_nibble(input logic [1:0] window);
        case (window)
            2'd0:    return `PERIPH_EMS_WIN_A;
            2'd1:    return `PERIPH_EMS_WIN_C;
            default: return `PERIPH_EMS_WIN_D;
        endcase
    endfunction

    // Table update needs one more edge after the write edge
    task automatic ems_write(input int slot, input bus_byte_t data);
        io_write({EMS_PORT[19:2], slot[1:0]}, data);
        if (ems_enabled_i) begin
            if (data == `PERIPH_EMS_DISABLE_CODE) begin
                model_en[slot] = 1'b0;
            end
            else if (data < 8'h80) begin
                model_page[slot] = data[6:0];
                model_en[slot]   = 1'b1;
            end
        end
        @(posedge clock);
        #1;
    endtask

    task automatic test_reset_values();
        check_value("data_bus_out_from_chipset_o", data_bus_out_from_chipset_o, 1'b0);
        check_value("data_bus_out_o", data_bus_out_o, 8'h00);
        read_and_check(LPT_PORT, 8'hFF, 1'b1);
        tandy_mode_i = 1'b1;
        read_and_check(NMI_PORT, 8'hFF, 1'b1);
        for (int k = 0; k < 4; k++) begin
            address_i       = {`PERIPH_EMS_WIN_A, k[1:0], 14'h0100};
            memory_read_n_i = 1'b0;
            #1;
            check_value("ems_hit_o", ems_hit_o, 4'b0000);
            @(posedge clock);
            #1;
            bus_idle();
        end
    endtask

    task automatic test_chip_selects();
        logic [4:0] expected;
        logic [4:0] none;
        none = 5'b11111;
        for (int blk = 0; blk < 5; blk++) begin
            expected           = none & ~(5'b10000 >> blk);
            address_i          = {10'h000, 2'b00, blk[2:0], 5'h0A};
            address_enable_n_i = 1'b0;
            io_read_n_i        = 1'b0;
            #1;
            check_value("cs_n read", {dma_cs_n_o, pic_cs_n_o, pit_cs_n_o, ppi_cs_n_o,
                        dma_page_cs_n_o}, expected);
            io_read_n_i  = 1'b1;
            io_write_n_i = 1'b0;
            #1;
            check_value("cs_n write", {dma_cs_n_o, pic_cs_n_o, pit_cs_n_o, ppi_cs_n_o,
                        dma_page_cs_n_o}, expected);
            io_write_n_i = 1'b1;
            @(posedge clock);
            #1;
            // Memory cycle with AEN still low
            memory_read_n_i = 1'b0;
            #1;
            check_value("cs_n memory", {dma_cs_n_o, pic_cs_n_o, pit_cs_n_o, ppi_cs_n_o,
                        dma_page_cs_n_o}, none);
            @(posedge clock);
            #1;
            bus_idle();
            // DMA cycle, AEN high
            io_read_n_i = 1'b0;
            #1;
            check_value("cs_n aen", {dma_cs_n_o, pic_cs_n_o, pit_cs_n_o, ppi_cs_n_o,
                        dma_page_cs_n_o}, none);
            address_enable_n_i = 1'b0;
            address_i[9:8]     = 2'b01;
            #1;
            check_value("cs_n high port", {dma_cs_n_o, pic_cs_n_o, pit_cs_n_o, ppi_cs_n_o,
                        dma_page_cs_n_o}, none);
            @(posedge clock);
            #1;
            bus_idle();
        end
    endtask

    task automatic test_port_latches();
        io_write(LPT_PORT, 8'h5A);
        read_and_check(LPT_PORT, 8'h5A, 1'b1);
        tandy_mode_i = 1'b1;
        io_write(NMI_PORT | 20'h3, 8'h3C);
        read_and_check(NMI_PORT | 20'h5, 8'h3C, 1'b1);
        tandy_mode_i = 1'b0;
        io_write(NMI_PORT | 20'h1, 8'hC3);
        read_and_check(NMI_PORT | 20'h1, 8'h00, 1'b0);
        tandy_mode_i = 1'b1;
        read_and_check(NMI_PORT, 8'h3C, 1'b1);
    endtask

    task automatic test_ems_rules();
        ems_enabled_i = 1'b1;
        ems_write(1, 8'h25);
        read_and_check(EMS_PORT | 20'h1, ems_expected(1), 1'b1);
        ems_write(1, 8'h9A);
        read_and_check(EMS_PORT | 20'h1, ems_expected(1), 1'b1);
        ems_write(1, 8'hFF);
        read_and_check(EMS_PORT | 20'h1, ems_expected(1), 1'b1);
        ems_write(1, 8'h12);
        read_and_check(EMS_PORT | 20'h1, ems_expected(1), 1'b1);
        ems_enabled_i = 1'b0;
        ems_write(2, 8'h33);
        read_and_check(EMS_PORT | 20'h2, 8'h00, 1'b0);
        ems_enabled_i = 1'b1;
        read_and_check(EMS_PORT | 20'h2, ems_expected(2), 1'b1);
    endtask

    task automatic test_ems_hits();
        logic [3:0] nib;
        ems_write(0, 8'h01);
        ems_write(1, 8'hFF);
        ems_write(2, 8'h7F);
        ems_write(3, 8'h40);
        for (int w = 0; w < 4; w++) begin
            ems_window_i = w[1:0];
            nib          = window_nibble(w[1:0]);
            for (int k = 0; k < 4; k++) begin
                address_i          = {nib, k[1:0], 14'h0ABC};
                address_enable_n_i = 1'b0;
                memory_read_n_i    = 1'b0;
                #1;
                check_value("ems_hit_o", ems_hit_o,
                            model_en[k] ? (4'b0001 << k) : 4'b0000);
                memory_read_n_i = 1'b1;
                io_read_n_i     = 1'b0;
                #1;
                check_value("ems_hit_o during I/O", ems_hit_o, 4'b0000);
                @(posedge clock);
                #1;
                bus_idle();
            end
            address_i       = {nib + 4'h1, 2'b00, 14'h0ABC};
            memory_read_n_i = 1'b0;
            #1;
            check_value("ems_hit_o outside window", ems_hit_o, 4'b0000);
            @(posedge clock);
            #1;
            bus_idle();
        end
        ems_write(1, 8'h11);
        address_i        = {window_nibble(ems_window_i), 2'b01, 14'h0000};
        memory_write_n_i = 1'b0;
        #1;
        check_value("ems_hit_o re-enabled", ems_hit_o, 4'b0010);
        @(posedge clock);
        #1;
        bus_idle();
    endtask

    task automatic test_read_priority();
        pic_data_i = $random(seed);
        pit_data_i = $random(seed);
        ppi_data_i = $random(seed);
        read_and_check(20'h00020, pic_data_i, 1'b1);
        read_and_check(20'h00041, pit_data_i, 1'b1);
        read_and_check(20'h00062, ppi_data_i, 1'b1);
        interrupt_acknowledge_n_i = 1'b0;
        read_and_check(LPT_PORT, pic_data_i, 1'b1);
        interrupt_acknowledge_n_i = 1'b0;
        read_and_check(20'h00040, pic_data_i, 1'b1);
        interrupt_acknowledge_n_i = 1'b0;
        read_and_check(EMS_PORT, pic_data_i, 1'b1);
        interrupt_acknowledge_n_i = 1'b0;
        @(posedge clock);
        #1;
        check_value("data_bus_out_o inta", data_bus_out_o, pic_data_i);
        bus_idle();
    endtask

    initial begin
        reset         = 1'b1;
        address_i     = 20'h00000;
        data_i        = 8'h00;
        ems_enabled_i = 1'b1;
        ems_window_i  = 2'd0;
        tandy_mode_i  = 1'b0;
        pic_data_i    = $random(seed);
        pit_data_i    = $random(seed);
        ppi_data_i    = $random(seed);
        bus_idle();
        for (int k = 0; k < 4; k++) begin
            model_page[k] = 7'h00;
            model_en[k]   = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
        test_reset_values();
        test_chip_selects();
        test_port_latches();
        test_ems_rules();
        test_ems_hits();
        test_read_priority();
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end
        else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+common
common/periph_pkg.sv
src/io_decode.sv
ems/ems_mapper.sv
src/port_latches.sv
src/read_mux.sv
src/periph_glue_top.sv
sim/tb_periph_glue.sv
